//--- demosaic_acpi.f
source/demosaic_pkg.sv
source/raw_line_window.sv
source/frame_pos_counter.sv
source/demosaic_ctrl_fsm.sv
source/acpi_g_calc.sv
source/demosaic_acpi_top.sv
tests/demosaic_acpi_sva.sv
tests/tb_demosaic_acpi.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_demosaic_acpi \
    -f demosaic_acpi.f --Mdir obj_dir -o sim_demosaic_acpi \
    && ./obj_dir/sim_demosaic_acpi 2>&1 | tee sim.log

grep -qs '^Done: no errors$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- source/acpi_g_calc.sv
// seven-stage ACPI green estimator with Bayer phase tracking and valid tags
`timescale 1ns/1ps
`default_nettype none

module acpi_g_calc #(
    parameter int DATA_BITS = demosaic_pkg::DEF_DATA_BITS
) (
    input  var logic clk,
    input  var logic rst_n,
    input  var logic cke,
    input  var demosaic_pkg::phase_t param_phase,
    input  var logic in_valid,
    input  var logic in_line_first,
    input  var logic in_pixel_first,
    input  var logic [demosaic_pkg::WIN_SIZE-1:0][demosaic_pkg::WIN_SIZE-1:0][DATA_BITS-1:0] in_raw,
    output logic out_valid,
    output logic out_line_first,
    output logic out_pixel_first,
    output logic [DATA_BITS-1:0] out_raw,
    output logic [DATA_BITS-1:0] out_g
);

    localparam int GUARD     = demosaic_pkg::CALC_GUARD;
    localparam int CALC_BITS = DATA_BITS + GUARD;
    localparam int N         = demosaic_pkg::PIPE_STAGES;
    localparam logic signed [CALC_BITS-1:0] MAX_VALUE = (1 <<< DATA_BITS) - 1;

    function automatic logic signed [CALC_BITS-1:0] ext(input logic [DATA_BITS-1:0] a);
        return $signed({{GUARD{1'b0}}, a});
    endfunction

    function automatic logic signed [CALC_BITS-1:0] abs_s(
        input logic signed [CALC_BITS-1:0] a
    );
        return (a < 0) ? -a : a;
    endfunction

    function automatic logic signed [CALC_BITS-1:0] abs_diff(
        input logic signed [CALC_BITS-1:0] a,
        input logic signed [CALC_BITS-1:0] b
    );
        return (a > b) ? a - b : b - a;
    endfunction

    // ------------------------------
    // control and tags
    // ------------------------------
    logic [N-1:0] tag_valid;
    logic [N-1:0] tag_pixel_first;
    logic [N-1:0] tag_line_first;
    demosaic_pkg::phase_t kept_phase;
    demosaic_pkg::phase_t st0_phase;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid       <= '0;
            tag_pixel_first <= '0;
            tag_line_first  <= '0;
            kept_phase      <= '0;
            st0_phase       <= '0;
        end else if (cke) begin
            tag_valid       <= {tag_valid[N-2:0], in_valid};
            tag_pixel_first <= {tag_pixel_first[N-2:0], in_pixel_first};
            tag_line_first  <= {tag_line_first[N-2:0], in_line_first};
            st0_phase[0]    <= ~st0_phase[0];
            if (in_pixel_first) begin
                if (in_line_first) begin
                    kept_phase <= param_phase;
                    st0_phase  <= param_phase;
                end else begin
                    st0_phase[0] <= kept_phase[0];
                    st0_phase[1] <= ~st0_phase[1];
                end
            end
        end
    end

    // ------------------------------
    // datapath
    // ------------------------------
    logic [DATA_BITS-1:0] st0_raw, st1_raw, st2_raw, st3_raw, st4_raw, st5_raw, st6_raw;
    demosaic_pkg::phase_t st1_phase, st2_phase, st3_phase, st4_phase, st5_phase;

    logic signed [CALC_BITS-1:0] st0_vo, st0_ho, st0_vd, st0_hd, st0_vs, st0_hs;
    logic signed [CALC_BITS-1:0] st1_lv, st1_lh, st1_vd, st1_hd, st1_vs, st1_hs;
    logic signed [CALC_BITS-1:0] st2_gv, st2_gh, st2_lv, st2_lh, st2_vs, st2_hs;
    logic signed [CALC_BITS-1:0] st3_g0, st3_g1;
    logic signed [CALC_BITS-1:0] st4_g;
    logic [DATA_BITS-1:0] st5_g;
    logic [DATA_BITS-1:0] st6_g;

    logic signed [CALC_BITS-1:0] est_v;
    logic signed [CALC_BITS-1:0] est_h;

    assign est_v = (st2_vs <<< 1) + st2_lv;
    assign est_h = (st2_hs <<< 1) + st2_lh;

    always_ff @(posedge clk) begin
        if (cke) begin
            // outer, inner difference and inner sum in both directions
            st0_raw <= in_raw[2][2];
            st0_vo  <= ext(in_raw[0][2]) + ext(in_raw[4][2]);
            st0_ho  <= ext(in_raw[2][0]) + ext(in_raw[2][4]);
            st0_vd  <= abs_diff(ext(in_raw[1][2]), ext(in_raw[3][2]));
            st0_hd  <= abs_diff(ext(in_raw[2][1]), ext(in_raw[2][3]));
            st0_vs  <= ext(in_raw[1][2]) + ext(in_raw[3][2]);
            st0_hs  <= ext(in_raw[2][1]) + ext(in_raw[2][3]);

            // laplacians
            st1_phase <= st0_phase;
            st1_raw   <= st0_raw;
            st1_lv    <= (ext(st0_raw) <<< 1) - st0_vo;
            st1_lh    <= (ext(st0_raw) <<< 1) - st0_ho;
            st1_vd    <= st0_vd;
            st1_hd    <= st0_hd;
            st1_vs    <= st0_vs;
            st1_hs    <= st0_hs;

            // gradients
            st2_phase <= st1_phase;
            st2_raw   <= st1_raw;
            st2_gv    <= abs_s(st1_lv) + st1_vd;
            st2_gh    <= abs_s(st1_lh) + st1_hd;
            st2_lv    <= st1_lv;
            st2_lh    <= st1_lh;
            st2_vs    <= st1_vs;
            st2_hs    <= st1_hs;

            // a tie keeps one estimate of each direction
            st3_phase <= st2_phase;
            st3_raw   <= st2_raw;
            st3_g0    <= (st2_gh < st2_gv) ? est_h : est_v;
            st3_g1    <= (st2_gv < st2_gh) ? est_v : est_h;

            st4_phase <= st3_phase;
            st4_raw   <= st3_raw;
            st4_g     <= (st3_g0 + st3_g1) >>> 3;

            st5_phase <= st4_phase;
            st5_raw   <= st4_raw;
            if (st4_g < 0) begin
                st5_g <= '0;
            end else if (st4_g > MAX_VALUE) begin
                st5_g <= '1;
            end else begin
                st5_g <= st4_g[DATA_BITS-1:0];
            end

            // green sites pass the raw sample
            st6_raw <= st5_raw;
            case (st5_phase)
                2'b00, 2'b11: st6_g <= st5_g;
                default:      st6_g <= st5_raw;
            endcase
        end
    end

    assign out_valid       = cke && tag_valid[N-1];
    assign out_pixel_first = out_valid && tag_pixel_first[N-1];
    assign out_line_first  = out_valid && tag_line_first[N-1];
    assign out_raw         = st6_raw;
    assign out_g           = st6_g;

endmodule

`default_nettype wire

//--- source/demosaic_acpi_top.sv
// ACPI green-channel demosaic top: window, position counter, control FSM, estimator
`timescale 1ns/1ps
`default_nettype none

module demosaic_acpi_top #(
    parameter int DATA_BITS  = demosaic_pkg::DEF_DATA_BITS,
    parameter int IMG_WIDTH  = 64,
    parameter int IMG_HEIGHT = 48
) (
    input  var logic clk,
    input  var logic rst_n,
    input  var logic in_valid,
    input  var logic in_frame_start,
    input  var logic [DATA_BITS-1:0] in_raw,
    input  var demosaic_pkg::phase_t param_phase,
    output logic out_valid,
    output logic out_line_first,
    output logic out_pixel_first,
    output logic [DATA_BITS-1:0] out_raw,
    output logic [DATA_BITS-1:0] out_g
);

    localparam int W = demosaic_pkg::WIN_SIZE;

    logic [W-1:0][W-1:0][DATA_BITS-1:0] win_raw;
    logic win_valid;
    logic win_pixel_first;
    logic win_line_first;
    logic frame_end;
    logic cke;

    raw_line_window #(
        .DATA_BITS (DATA_BITS),
        .IMG_WIDTH (IMG_WIDTH)
    ) u_window (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_raw   (in_raw),
        .win_raw  (win_raw)
    );

    frame_pos_counter #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_counter (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_frame_start  (in_frame_start),
        .win_valid       (win_valid),
        .win_pixel_first (win_pixel_first),
        .win_line_first  (win_line_first),
        .frame_end       (frame_end)
    );

    demosaic_ctrl_fsm u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_frame_start (in_frame_start),
        .frame_end      (frame_end),
        .cke            (cke)
    );

    acpi_g_calc #(
        .DATA_BITS (DATA_BITS)
    ) u_calc (
        .clk             (clk),
        .rst_n           (rst_n),
        .cke             (cke),
        .param_phase     (param_phase),
        .in_valid        (win_valid),
        .in_line_first   (win_line_first),
        .in_pixel_first  (win_pixel_first),
        .in_raw          (win_raw),
        .out_valid       (out_valid),
        .out_line_first  (out_line_first),
        .out_pixel_first (out_pixel_first),
        .out_raw         (out_raw),
        .out_g           (out_g)
    );

endmodule

`default_nettype wire

//--- source/demosaic_ctrl_fsm.sv
// frame control FSM for the pipeline clock enable and end-of-frame drain
`timescale 1ns/1ps
`default_nettype none

module demosaic_ctrl_fsm (
    input  var logic clk,
    input  var logic rst_n,
    input  var logic in_valid,
    input  var logic in_frame_start,
    input  var logic frame_end,
    output logic cke
);

    localparam int STAGES   = demosaic_pkg::PIPE_STAGES;
    localparam int CNT_BITS = $clog2(STAGES);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } state_t;

    state_t state;
    logic [CNT_BITS-1:0] drain_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            drain_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (in_valid && in_frame_start) begin
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    if (frame_end) begin
                        state     <= ST_DRAIN;
                        drain_cnt <= CNT_BITS'(STAGES - 1);
                    end
                end
                ST_DRAIN: begin
                    // push the last window out, then wait for a frame start
                    if (drain_cnt == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        case (state)
            ST_IDLE:  cke = in_valid && in_frame_start;
            ST_RUN:   cke = in_valid;
            ST_DRAIN: cke = 1'b1;
            default:  cke = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/demosaic_pkg.sv
// shared constants and Bayer phase type for the green demosaic stage
`default_nettype none

package demosaic_pkg;

    // bit 0 column parity, bit 1 row parity
    // 00 and 11 are red/blue sites, 01 and 10 are green
    typedef logic [1:0] phase_t;

    localparam int DEF_DATA_BITS = 10;

    // signed headroom above the sample width
    localparam int CALC_GUARD    = 6;

    localparam int PIPE_STAGES   = 7;
    localparam int WIN_SIZE      = 5;

endpackage

`default_nettype wire

//--- source/frame_pos_counter.sv
// column and row position counters with interior, first-pixel and frame-end flags
`timescale 1ns/1ps
`default_nettype none

module frame_pos_counter #(
    parameter int IMG_WIDTH  = 64,
    parameter int IMG_HEIGHT = 48
) (
    input  var logic clk,
    input  var logic rst_n,
    input  var logic in_valid,
    input  var logic in_frame_start,
    output logic win_valid,
    output logic win_pixel_first,
    output logic win_line_first,
    output logic frame_end
);

    localparam int COL_BITS = $clog2(IMG_WIDTH);
    localparam int ROW_BITS = $clog2(IMG_HEIGHT);
    localparam int EDGE     = demosaic_pkg::WIN_SIZE - 1;

    logic [COL_BITS-1:0] col_q;
    logic [COL_BITS-1:0] col_cur;
    logic [ROW_BITS-1:0] row_q;
    logic [ROW_BITS-1:0] row_cur;
    logic col_last;
    logic row_last;

    // position of the pixel on this strobe
    assign col_cur  = in_frame_start ? '0 : col_q;
    assign row_cur  = in_frame_start ? '0 : row_q;
    assign col_last = (col_cur == COL_BITS'(IMG_WIDTH - 1));
    assign row_last = (row_cur == ROW_BITS'(IMG_HEIGHT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (in_valid) begin
            if (col_last) begin
                col_q <= '0;
                row_q <= row_last ? '0 : row_cur + 1'b1;
            end else begin
                col_q <= col_cur + 1'b1;
                row_q <= row_cur;
            end
        end
    end

    // window centre sits two back in both directions
    assign win_valid       = in_valid && (col_cur >= COL_BITS'(EDGE))
                             && (row_cur >= ROW_BITS'(EDGE));
    assign win_pixel_first = win_valid && (col_cur == COL_BITS'(EDGE));
    assign win_line_first  = win_pixel_first && (row_cur == ROW_BITS'(EDGE));
    assign frame_end       = in_valid && col_last && row_last;

endmodule

`default_nettype wire

//--- source/raw_line_window.sv
// four line buffers and a 5x5 shift window over the raw pixel stream
`timescale 1ns/1ps
`default_nettype none

module raw_line_window #(
    parameter int DATA_BITS = demosaic_pkg::DEF_DATA_BITS,
    parameter int IMG_WIDTH = 64
) (
    input  var logic clk,
    input  var logic rst_n,
    input  var logic in_valid,
    input  var logic [DATA_BITS-1:0] in_raw,
    output logic [demosaic_pkg::WIN_SIZE-1:0][demosaic_pkg::WIN_SIZE-1:0][DATA_BITS-1:0] win_raw
);

    localparam int W        = demosaic_pkg::WIN_SIZE;
    localparam int PTR_BITS = $clog2(IMG_WIDTH);

    // line 0 holds the oldest row
    logic [DATA_BITS-1:0] line_mem [W-1][IMG_WIDTH];
    logic [PTR_BITS-1:0] wr_ptr;

    logic [W-1:0][DATA_BITS-1:0] tap;
    logic [W-1:0][W-2:0][DATA_BITS-1:0] hist;

    // one column pointer shared by all lines
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (in_valid) begin
            if (wr_ptr == PTR_BITS'(IMG_WIDTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // five-tap column, newest pixel at the bottom
    always_comb begin
        for (int r = 0; r < W - 1; r++) begin
            tap[r] = line_mem[r][wr_ptr];
        end
        tap[W-1] = in_raw;
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int r = 0; r < W - 1; r++) begin
                line_mem[r][wr_ptr] <= tap[r+1];
            end
            for (int r = 0; r < W; r++) begin
                for (int c = 0; c < W - 2; c++) begin
                    hist[r][c] <= hist[r][c+1];
                end
                hist[r][W-2] <= tap[r];
            end
        end
    end

    // newest column straight from the taps
    always_comb begin
        for (int r = 0; r < W; r++) begin
            for (int c = 0; c < W - 1; c++) begin
                win_raw[r][c] = hist[r][c];
            end
            win_raw[r][W-1] = tap[r];
        end
    end

endmodule

`default_nettype wire

//--- tests/demosaic_acpi_sva.sv
// control FSM assertions on idle enable, drain length and frame start during drain
`timescale 1ns/1ps
`default_nettype none

module demosaic_ctrl_sva (
    input var logic clk,
    input var logic rst_n,
    input var logic in_valid,
    input var logic in_frame_start,
    input var logic cke,
    input var logic [1:0] state
);

    localparam int STAGES = demosaic_pkg::PIPE_STAGES;
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_DRAIN = 2'd2;

    int drain_len;

    // cycles spent in drain so far
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drain_len <= 0;
        end else if (state == ST_DRAIN) begin
            drain_len <= drain_len + 1;
        end else begin
            drain_len <= 0;
        end
    end

    idle_cke_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_IDLE && cke) |-> in_valid)
        else $error("cke high in idle without a pixel strobe");

    drain_exact_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(state == ST_DRAIN) |-> (drain_len == STAGES))
        else $error("drain lasted %0d cycles instead of %0d", drain_len, STAGES);

    no_start_in_drain: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_DRAIN) |-> !(in_valid && in_frame_start))
        else $error("frame start strobe arrived while draining");

endmodule

bind demosaic_ctrl_fsm demosaic_ctrl_sva u_ctrl_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_frame_start (in_frame_start),
    .cke            (cke),
    .state          (state)
);

`default_nettype wire

//--- tests/tb_demosaic_acpi.sv
// testbench for the ACPI green demosaic: random frames, reference model, checker, timeout
`timescale 1ns/1ps
`default_nettype none

module tb_demosaic_acpi;

    localparam int DATA_BITS  = 10;
    localparam int IMG_WIDTH  = 12;
    localparam int IMG_HEIGHT = 10;
    localparam int NUM_FRAMES = 5;
    localparam int FRAME_GAP  = 10;
    localparam int MAX_GAP    = 3;
    localparam int NUM_PIXELS = IMG_WIDTH * IMG_HEIGHT;
    localparam int PER_FRAME  = (IMG_WIDTH - 4) * (IMG_HEIGHT - 4);
    localparam int MAX_VALUE  = (1 << DATA_BITS) - 1;
    localparam int TIMEOUT_CYCLES = 2 * (NUM_PIXELS * (MAX_GAP + 1) + FRAME_GAP) * NUM_FRAMES;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic in_frame_start;
    logic [DATA_BITS-1:0] in_raw;
    demosaic_pkg::phase_t param_phase;
    logic out_valid;
    logic out_line_first;
    logic out_pixel_first;
    logic [DATA_BITS-1:0] out_raw;
    logic [DATA_BITS-1:0] out_g;

    logic [31:0] rng_state = 32'h49be_28cb;
    int pix [IMG_HEIGHT][IMG_WIDTH];
    int exp_raw_q[$];
    int exp_g_q[$];
    int exp_pf_q[$];
    int exp_lf_q[$];
    int frame_results;
    int total_results;
    int cycle_count;

    demosaic_acpi_top #(
        .DATA_BITS  (DATA_BITS),
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_frame_start  (in_frame_start),
        .in_raw          (in_raw),
        .param_phase     (param_phase),
        .out_valid       (out_valid),
        .out_line_first  (out_line_first),
        .out_pixel_first (out_pixel_first),
        .out_raw         (out_raw),
        .out_g           (out_g)
    );

    always #50 clk = ~clk;

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // extremes often, so clamps and gradient ties show up
    function automatic int pick_pixel();
        logic [31:0] r;
        r = next_rand();
        case (r[31:30])
            2'd0:    return 0;
            2'd1:    return MAX_VALUE;
            default: return int'(r[16 +: DATA_BITS]);
        endcase
    endfunction

    function automatic int abs_int(input int a);
        return (a < 0) ? -a : a;
    endfunction

    function automatic int green_estimate(input int cx, input int cy);
        int c;
        int lv;
        int lh;
        int gv;
        int gh;
        int ev;
        int eh;
        int g0;
        int g1;
        int s;
        c  = pix[cy][cx];
        lv = 2 * c - (pix[cy-2][cx] + pix[cy+2][cx]);
        lh = 2 * c - (pix[cy][cx-2] + pix[cy][cx+2]);
        gv = abs_int(lv) + abs_int(pix[cy-1][cx] - pix[cy+1][cx]);
        gh = abs_int(lh) + abs_int(pix[cy][cx-1] - pix[cy][cx+1]);
        ev = 2 * (pix[cy-1][cx] + pix[cy+1][cx]) + lv;
        eh = 2 * (pix[cy][cx-1] + pix[cy][cx+1]) + lh;
        g0 = (gh < gv) ? eh : ev;
        g1 = (gv < gh) ? ev : eh;
        s  = (g0 + g1) >>> 3;
        if (s < 0) begin
            s = 0;
        end else if (s > MAX_VALUE) begin
            s = MAX_VALUE;
        end
        return s;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                name, got, expected));
        end
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    task automatic fill_frame();
        for (int y = 0; y < IMG_HEIGHT; y++) begin
            for (int x = 0; x < IMG_WIDTH; x++) begin
                pix[y][x] = pick_pixel();
            end
        end
    endtask

    task automatic queue_expected(input demosaic_pkg::phase_t phase);
        int i;
        int j;
        logic [1:0] site;
        for (int cy = 2; cy < IMG_HEIGHT - 2; cy++) begin
            for (int cx = 2; cx < IMG_WIDTH - 2; cx++) begin
                i = cx - 2;
                j = cy - 2;
                site[0] = phase[0] ^ i[0];
                site[1] = phase[1] ^ j[0];
                exp_raw_q.push_back(pix[cy][cx]);
                if (site == 2'b00 || site == 2'b11) begin
                    exp_g_q.push_back(green_estimate(cx, cy));
                end else begin
                    exp_g_q.push_back(pix[cy][cx]);
                end
                exp_pf_q.push_back((cx == 2) ? 1 : 0);
                exp_lf_q.push_back((cx == 2 && cy == 2) ? 1 : 0);
            end
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic idle_cycle();
        @(posedge clk);
        #1;
        in_valid       = 1'b0;
        in_frame_start = 1'b0;
    endtask

    task automatic send_pixel(input int value, input logic first);
        @(posedge clk);
        #1;
        in_valid       = 1'b1;
        in_frame_start = first;
        in_raw         = DATA_BITS'(value);
    endtask

    task automatic send_frame();
        logic [31:0] r;
        for (int y = 0; y < IMG_HEIGHT; y++) begin
            for (int x = 0; x < IMG_WIDTH; x++) begin
                r = next_rand();
                repeat (int'(r[31:30])) idle_cycle();
                send_pixel(pix[y][x], (x == 0 && y == 0));
            end
        end
        repeat (FRAME_GAP) idle_cycle();
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_g_q.size() == 0) begin
                abort_run("out_valid went high with no result expected");
            end else begin
                check_value("out_raw", 32'(out_raw), exp_raw_q.pop_front());
                check_value("out_g", 32'(out_g), exp_g_q.pop_front());
                check_value("out_pixel_first", 32'(out_pixel_first), exp_pf_q.pop_front());
                check_value("out_line_first", 32'(out_line_first), exp_lf_q.pop_front());
                frame_results++;
                total_results++;
            end
        end else if (rst_n) begin
            check_value("out_pixel_first", 32'(out_pixel_first), 32'd0);
            check_value("out_line_first", 32'(out_line_first), 32'd0);
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run("timeout: the run did not finish within the cycle limit");
        end
    end

    initial begin
        demosaic_pkg::phase_t phase;
        logic [31:0] r;
        clk            = 1'b0;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_frame_start = 1'b0;
        in_raw         = '0;
        param_phase    = '0;
        frame_results  = 0;
        total_results  = 0;
        cycle_count    = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // quiet stretch after reset
        repeat (8) idle_cycle();
        r = next_rand();
        phase = r[31:30];
        for (int f = 0; f < NUM_FRAMES; f++) begin
            fill_frame();
            queue_expected(phase);
            frame_results = 0;
            param_phase   = phase;
            send_frame();
            check_value("results per frame", frame_results, PER_FRAME);
            check_value("pending results after drain", exp_g_q.size(), 0);
            r = next_rand();
            phase = phase + 2'(1 + (r[31:28] % 3));
        end
        if (exp_g_q.size() == 0 && total_results == NUM_FRAMES * PER_FRAME) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run("wrong number of results at the end of the run");
        end
    end

endmodule

`default_nettype wire
